// File: Makefile
TOP := soc_bus_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

obj_dir/V$(TOP): all.f $(wildcard src/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f all.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
src/soc_pkg.sv
src/wb_bridge.sv
src/wb_intercon.sv
src/data_mem.sv
src/gpio_port.sv
src/clint_timer.sv
src/soc_bus_top.sv
test/soc_bus_properties.sv
test/soc_bus_tb.sv

// File: src/clint_timer.sv
module clint_timer (
    input  logic             clk,
    input  logic             reset_i,
    input  soc_pkg::wb_m2s_t wb_i,
    output soc_pkg::wb_s2m_t wb_o,
    output logic             timer_irq_o
);

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic [31:0] rdata_q;
    logic        ack_q;
    logic        irq_q;
    logic        access;
    logic        wr;
    logic [11:0] offset;

    assign offset = wb_i.adr[11:0];
    assign access = wb_i.cyc & wb_i.stb & ~ack_q;
    assign wr     = access & wb_i.we;

    // ========================================
    // mtime, free running, word writable
    // ========================================
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            mtime_q <= 64'h0;
        end
        else if (wr && offset == soc_pkg::MTIME_LO)
        begin
            mtime_q[31:0] <= soc_pkg::merge_lanes(mtime_q[31:0], wb_i.dat, wb_i.sel);
        end
        else if (wr && offset == soc_pkg::MTIME_HI)
        begin
            mtime_q[63:32] <= soc_pkg::merge_lanes(mtime_q[63:32], wb_i.dat, wb_i.sel);
        end
        else
        begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // compare value, all ones keeps irq off
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            mtimecmp_q <= '1;
        end
        else if (wr && offset == soc_pkg::MTIMECMP_LO)
        begin
            mtimecmp_q[31:0] <= soc_pkg::merge_lanes(mtimecmp_q[31:0], wb_i.dat, wb_i.sel);
        end
        else if (wr && offset == soc_pkg::MTIMECMP_HI)
        begin
            mtimecmp_q[63:32] <= soc_pkg::merge_lanes(mtimecmp_q[63:32], wb_i.dat, wb_i.sel);
        end
    end

    // read mux, ack and registered irq
    always_ff @(posedge clk)
    begin
        if (access)
        begin
            case (offset)
                soc_pkg::MTIME_LO:    rdata_q <= mtime_q[31:0];
                soc_pkg::MTIME_HI:    rdata_q <= mtime_q[63:32];
                soc_pkg::MTIMECMP_LO: rdata_q <= mtimecmp_q[31:0];
                soc_pkg::MTIMECMP_HI: rdata_q <= mtimecmp_q[63:32];
                default:              rdata_q <= 32'h0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            ack_q <= 1'b0;
            irq_q <= 1'b0;
        end
        else
        begin
            ack_q <= access;
            irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign wb_o        = '{dat: rdata_q, ack: ack_q, err: 1'b0};
    assign timer_irq_o = irq_q;

endmodule

// File: src/data_mem.sv
module data_mem (
    input  logic             clk,
    input  logic             reset_i,
    input  soc_pkg::wb_m2s_t wb_i,
    output soc_pkg::wb_s2m_t wb_o
);

    logic [31:0]               mem [soc_pkg::DMEM_WORDS];
    logic [31:0]               rdata_q;
    logic                      ack_q;
    logic [soc_pkg::DMEM_AW-1:0] word_idx;
    logic                      access;

    // word index wraps modulo depth
    assign word_idx = wb_i.adr[soc_pkg::DMEM_AW+1:2];

    // new strobe only, not the cycle that already acks
    assign access = wb_i.cyc & wb_i.stb & ~ack_q;

    // ========================================
    // storage, byte lanes under sel
    // ========================================
    always_ff @(posedge clk)
    begin
        if (access && wb_i.we)
        begin
            mem[word_idx] <= soc_pkg::merge_lanes(mem[word_idx], wb_i.dat, wb_i.sel);
        end
    end

    // registered read, valid with ack
    always_ff @(posedge clk)
    begin
        if (access)
        begin
            rdata_q <= mem[word_idx];
        end
    end

    // ack pulse one clock after stb
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            ack_q <= access;
        end
    end

    // never errors
    assign wb_o = '{dat: rdata_q, ack: ack_q, err: 1'b0};

endmodule

// File: src/gpio_port.sv
module gpio_port (
    input  logic             clk,
    input  logic             reset_i,
    input  soc_pkg::wb_m2s_t wb_i,
    output soc_pkg::wb_s2m_t wb_o,
    input  logic [31:0]      gpio_in_i,
    output logic [31:0]      gpio_out_o,
    output logic [31:0]      gpio_oe_o
);

    logic [31:0] out_q;
    logic [31:0] oe_q;
    logic [31:0] in_meta_q;
    logic [31:0] in_sync_q;
    logic [31:0] rdata_q;
    logic        ack_q;
    logic        access;
    logic [11:0] offset;

    assign offset = wb_i.adr[11:0];
    assign access = wb_i.cyc & wb_i.stb & ~ack_q;

    // ========================================
    // output and enable registers
    // ========================================
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            out_q <= 32'h0;
            oe_q  <= 32'h0;
        end
        else if (access && wb_i.we)
        begin
            // unknown offsets and GPIO_IN drop the write
            if (offset == soc_pkg::GPIO_OUT)
            begin
                out_q <= soc_pkg::merge_lanes(out_q, wb_i.dat, wb_i.sel);
            end
            else if (offset == soc_pkg::GPIO_OE)
            begin
                oe_q <= soc_pkg::merge_lanes(oe_q, wb_i.dat, wb_i.sel);
            end
        end
    end

    // two-flop sync on the pins
    always_ff @(posedge clk)
    begin
        in_meta_q <= gpio_in_i;
        in_sync_q <= in_meta_q;
    end

    // read mux, registered
    always_ff @(posedge clk)
    begin
        if (access)
        begin
            case (offset)
                soc_pkg::GPIO_OUT: rdata_q <= out_q;
                soc_pkg::GPIO_OE:  rdata_q <= oe_q;
                soc_pkg::GPIO_IN:  rdata_q <= in_sync_q;
                default:           rdata_q <= 32'h0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            ack_q <= access;
        end
    end

    assign wb_o       = '{dat: rdata_q, ack: ack_q, err: 1'b0};
    assign gpio_out_o = out_q;
    assign gpio_oe_o  = oe_q;

endmodule

// File: src/soc_bus_top.sv
module soc_bus_top (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               req_i,
    input  soc_pkg::proc_req_t req_data_i,
    output logic               ack_o,
    output soc_pkg::proc_rsp_t rsp_o,
    input  logic [31:0]        gpio_in_i,
    output logic [31:0]        gpio_out_o,
    output logic [31:0]        gpio_oe_o,
    output logic               timer_irq_o
);

    // master side of the shared bus
    soc_pkg::wb_m2s_t bus_m2s;
    soc_pkg::wb_s2m_t bus_s2m;

    // per-slave links
    soc_pkg::wb_m2s_t dmem_m2s;
    soc_pkg::wb_s2m_t dmem_s2m;
    soc_pkg::wb_m2s_t gpio_m2s;
    soc_pkg::wb_s2m_t gpio_s2m;
    soc_pkg::wb_m2s_t clint_m2s;
    soc_pkg::wb_s2m_t clint_s2m;

    // ========================================
    // bus master
    // ========================================
    wb_bridge u_bridge (
        .clk        (clk),
        .reset_i    (reset_i),
        .req_i      (req_i),
        .req_data_i (req_data_i),
        .ack_o      (ack_o),
        .rsp_o      (rsp_o),
        .wb_o       (bus_m2s),
        .wb_i       (bus_s2m)
    );

    // ========================================
    // interconnect and slaves
    // ========================================
    wb_intercon u_intercon (
        .clk     (clk),
        .reset_i (reset_i),
        .m_i     (bus_m2s),
        .m_o     (bus_s2m),
        .dmem_o  (dmem_m2s),
        .gpio_o  (gpio_m2s),
        .clint_o (clint_m2s),
        .dmem_i  (dmem_s2m),
        .gpio_i  (gpio_s2m),
        .clint_i (clint_s2m)
    );

    data_mem u_dmem (
        .clk     (clk),
        .reset_i (reset_i),
        .wb_i    (dmem_m2s),
        .wb_o    (dmem_s2m)
    );

    gpio_port u_gpio (
        .clk        (clk),
        .reset_i    (reset_i),
        .wb_i       (gpio_m2s),
        .wb_o       (gpio_s2m),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .gpio_oe_o  (gpio_oe_o)
    );

    clint_timer u_clint (
        .clk         (clk),
        .reset_i     (reset_i),
        .wb_i        (clint_m2s),
        .wb_o        (clint_s2m),
        .timer_irq_o (timer_irq_o)
    );

endmodule

// File: src/soc_pkg.sv
package soc_pkg;

    // ========================================
    // address map and memory size
    // ========================================

    // regions decoded on adr[31:12], 4 KiB each
    localparam logic [31:0] DMEM_BASE  = 32'h0000_0000;
    localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [31:0] GPIO_BASE  = 32'h2000_0000;

    // data memory depth in 32-bit words
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // gpio register offsets
    localparam logic [11:0] GPIO_OUT = 12'h000;
    localparam logic [11:0] GPIO_OE  = 12'h004;
    localparam logic [11:0] GPIO_IN  = 12'h008;

    // clint register offsets
    localparam logic [11:0] MTIME_LO    = 12'h000;
    localparam logic [11:0] MTIME_HI    = 12'h004;
    localparam logic [11:0] MTIMECMP_LO = 12'h008;
    localparam logic [11:0] MTIMECMP_HI = 12'h00C;

    // ========================================
    // enums and bus structs
    // ========================================

    // load/store width, coded like rv32 funct3
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'b000,
        MEM_HALF   = 3'b001,
        MEM_WORD   = 3'b010,
        MEM_BYTE_U = 3'b100,
        MEM_HALF_U = 3'b101
    } mem_op_e;

    typedef enum logic [1:0] {
        REGION_DMEM,
        REGION_GPIO,
        REGION_CLINT,
        REGION_NONE
    } region_e;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        write;
        mem_op_e     op;
    } proc_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } proc_rsp_t;

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_m2s_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
        logic        err;
    } wb_s2m_t;

    // byte-lane write merge, shared by all slaves
    function automatic logic [31:0] merge_lanes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  sel
    );
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++)
        begin
            if (sel[i])
            begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

endpackage

// File: src/wb_bridge.sv
module wb_bridge (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               req_i,
    input  soc_pkg::proc_req_t req_data_i,
    output logic               ack_o,
    output soc_pkg::proc_rsp_t rsp_o,
    output soc_pkg::wb_m2s_t   wb_o,
    input  soc_pkg::wb_s2m_t   wb_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_DONE
    } state_e;

    state_e      state;
    logic        bus_q;
    logic [31:0] adr_q;
    logic [31:0] dat_q;
    logic [3:0]  sel_q;
    logic        we_q;
    logic [31:0] rdata_q;
    logic        err_q;

    logic [3:0]  sel;
    logic [31:0] wdata_lanes;
    logic        misaligned;
    logic [31:0] lane_data;
    logic [31:0] load_data;
    logic        bus_done;

    // ========================================
    // lane steering for stores
    // ========================================
    always_comb
    begin
        case (req_data_i.op)
            soc_pkg::MEM_BYTE, soc_pkg::MEM_BYTE_U:
            begin
                sel         = 4'b0001 << req_data_i.addr[1:0];
                wdata_lanes = {4{req_data_i.wdata[7:0]}};
                misaligned  = 1'b0;
            end
            soc_pkg::MEM_HALF, soc_pkg::MEM_HALF_U:
            begin
                sel         = req_data_i.addr[1] ? 4'b1100 : 4'b0011;
                wdata_lanes = {2{req_data_i.wdata[15:0]}};
                misaligned  = req_data_i.addr[0];
            end
            soc_pkg::MEM_WORD:
            begin
                sel         = 4'b1111;
                wdata_lanes = req_data_i.wdata;
                misaligned  = |req_data_i.addr[1:0];
            end
            default:
            begin
                // reserved op codes get refused like a misalign
                sel         = 4'b0000;
                wdata_lanes = req_data_i.wdata;
                misaligned  = 1'b1;
            end
        endcase
    end

    // ========================================
    // load lane pick and extension
    // ========================================
    always_comb
    begin
        // addressed lane down to bit 0
        lane_data = wb_i.dat >> {req_data_i.addr[1:0], 3'b000};
        case (req_data_i.op)
            soc_pkg::MEM_BYTE:   load_data = {{24{lane_data[7]}}, lane_data[7:0]};
            soc_pkg::MEM_BYTE_U: load_data = {24'h0, lane_data[7:0]};
            soc_pkg::MEM_HALF:   load_data = {{16{lane_data[15]}}, lane_data[15:0]};
            soc_pkg::MEM_HALF_U: load_data = {16'h0, lane_data[15:0]};
            default:             load_data = lane_data;
        endcase
    end

    assign bus_done = wb_i.ack | wb_i.err;

    // handshake and bus cycle control
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            state <= ST_IDLE;
            ack_o <= 1'b0;
            bus_q <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (req_i && misaligned)
                    begin
                        // refused here, bus untouched
                        state <= ST_DONE;
                        ack_o <= 1'b1;
                    end
                    else if (req_i)
                    begin
                        state <= ST_BUS;
                        bus_q <= 1'b1;
                    end
                end
                ST_BUS:
                begin
                    if (bus_done)
                    begin
                        state <= ST_DONE;
                        ack_o <= 1'b1;
                        bus_q <= 1'b0;
                    end
                end
                ST_DONE:
                begin
                    // hold response until master lets go
                    if (!req_i)
                    begin
                        state <= ST_IDLE;
                        ack_o <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && req_i)
        begin
            adr_q   <= {req_data_i.addr[31:2], 2'b00};
            dat_q   <= wdata_lanes;
            sel_q   <= sel;
            we_q    <= req_data_i.write;
            rdata_q <= 32'h0;
            err_q   <= misaligned;
        end
        else if (state == ST_BUS && bus_done)
        begin
            rdata_q <= wb_i.err ? 32'h0 : load_data;
            err_q   <= wb_i.err;
        end
    end

    // classic cycle, stb tracks cyc
    assign wb_o = '{adr: adr_q, dat: dat_q, sel: sel_q, we: we_q, cyc: bus_q, stb: bus_q};
    assign rsp_o = '{rdata: rdata_q, err: err_q};

endmodule

// File: src/wb_intercon.sv
module wb_intercon (
    input  logic             clk,
    input  logic             reset_i,
    input  soc_pkg::wb_m2s_t m_i,
    output soc_pkg::wb_s2m_t m_o,
    output soc_pkg::wb_m2s_t dmem_o,
    output soc_pkg::wb_m2s_t gpio_o,
    output soc_pkg::wb_m2s_t clint_o,
    input  soc_pkg::wb_s2m_t dmem_i,
    input  soc_pkg::wb_s2m_t gpio_i,
    input  soc_pkg::wb_s2m_t clint_i
);

    soc_pkg::region_e region;
    logic             none_err_q;

    // ========================================
    // address decode on bits 31..12
    // ========================================
    always_comb
    begin
        if (m_i.adr[31:12] == soc_pkg::DMEM_BASE[31:12])
        begin
            region = soc_pkg::REGION_DMEM;
        end
        else if (m_i.adr[31:12] == soc_pkg::GPIO_BASE[31:12])
        begin
            region = soc_pkg::REGION_GPIO;
        end
        else if (m_i.adr[31:12] == soc_pkg::CLINT_BASE[31:12])
        begin
            region = soc_pkg::REGION_CLINT;
        end
        else
        begin
            region = soc_pkg::REGION_NONE;
        end
    end

    // fan out, only the hit slave sees stb
    always_comb
    begin
        dmem_o      = m_i;
        gpio_o      = m_i;
        clint_o     = m_i;
        dmem_o.stb  = m_i.stb & (region == soc_pkg::REGION_DMEM);
        gpio_o.stb  = m_i.stb & (region == soc_pkg::REGION_GPIO);
        clint_o.stb = m_i.stb & (region == soc_pkg::REGION_CLINT);
    end

    // unmapped address, one-cycle error pulse after stb
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            none_err_q <= 1'b0;
        end
        else
        begin
            none_err_q <= m_i.cyc & m_i.stb & (region == soc_pkg::REGION_NONE) & ~none_err_q;
        end
    end

    // response mux back to the master
    always_comb
    begin
        case (region)
            soc_pkg::REGION_DMEM:  m_o = dmem_i;
            soc_pkg::REGION_GPIO:  m_o = gpio_i;
            soc_pkg::REGION_CLINT: m_o = clint_i;
            default:               m_o = '{dat: 32'h0, ack: 1'b0, err: none_err_q};
        endcase
    end

endmodule

// File: test/soc_bus_properties.sv
module soc_bus_properties (
    input logic               clk,
    input logic               reset_i,
    input logic               req_i,
    input logic               ack_i,
    input soc_pkg::proc_rsp_t rsp_i,
    input soc_pkg::wb_m2s_t   m2s_i,
    input logic               irq_i
);

    // number of failed properties so far
    int fail_count = 0;

    // ========================================
    // processor port handshake
    // ========================================

    // ack only answers a live request
    ack_needs_req: assert property (
        @(posedge clk) disable iff (reset_i) $rose(ack_i) |-> req_i
    )
    else
    begin
        $error("ack_o rose while req_i was low");
        fail_count++;
    end

    // ack held until the master lets go
    ack_held: assert property (
        @(posedge clk) disable iff (reset_i) ack_i && req_i |=> ack_i
    )
    else
    begin
        $error("ack_o dropped before req_i fell");
        fail_count++;
    end

    // response frozen for the whole ack phase
    rsp_stable: assert property (
        @(posedge clk) disable iff (reset_i) ack_i && $past(ack_i) |-> $stable(rsp_i)
    )
    else
    begin
        $error("rsp_o changed while ack_o was high");
        fail_count++;
    end

    // clean outputs straight out of reset
    reset_quiet: assert property (
        @(posedge clk) reset_i |=> !ack_i && !irq_i
    )
    else
    begin
        $error("ack_o or timer_irq_o high after reset");
        fail_count++;
    end

    // bus cycle over before ack goes out
    no_cyc_in_ack: assert property (
        @(posedge clk) disable iff (reset_i) ack_i |-> !m2s_i.cyc
    )
    else
    begin
        $error("wishbone cyc high during ack_o");
        fail_count++;
    end

endmodule

bind soc_bus_top soc_bus_properties props (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (req_i),
    .ack_i   (ack_o),
    .rsp_i   (rsp_o),
    .m2s_i   (bus_m2s),
    .irq_i   (timer_irq_o)
);

// File: test/soc_bus_tb.sv
module soc_bus_tb;

    localparam int WAIT_LIMIT = 200;

    logic               clk;
    logic               reset_i;
    logic               req_i;
    soc_pkg::proc_req_t req_data;
    logic               ack;
    soc_pkg::proc_rsp_t rsp;
    logic [31:0]        gpio_in;
    logic [31:0]        gpio_out;
    logic [31:0]        gpio_oe;
    logic               timer_irq;

    // lfsr state and shadow of the data memory
    logic [15:0] lfsr_q;
    logic [31:0] shadow [soc_pkg::DMEM_WORDS];
    int          word_list [6];

    soc_bus_top DUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_i       (req_i),
        .req_data_i  (req_data),
        .ack_o       (ack),
        .rsp_o       (rsp),
        .gpio_in_i   (gpio_in),
        .gpio_out_o  (gpio_out),
        .gpio_oe_o   (gpio_oe),
        .timer_irq_o (timer_irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================
    // failure handling and value checks
    // ========================================
    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("ERR %s expected %08h actual %08h", name, exp, act);
            stop_run();
        end
    endtask

    // any bound property failure ends the run
    always @(negedge clk)
    begin
        if (DUT.props.fail_count != 0)
        begin
            $display("a bus protocol assertion failed");
            stop_run();
        end
    end

    // 16-bit fibonacci, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] result;
        logic        fb;
        result = 32'h0;
        for (int i = 0; i < count; i++)
        begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            result = {result[30:0], fb};
        end
        return result;
    endfunction

    // ========================================
    // shadow model
    // ========================================

    // word addresses wrap at the memory depth
    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        return shadow[addr[soc_pkg::DMEM_AW+1:2]];
    endfunction

    function automatic void shadow_store(
        input logic [31:0]      addr,
        input logic [31:0]      data,
        input soc_pkg::mem_op_e op
    );
        logic [31:0] mask;
        int          shift;
        shift = 8 * int'(addr[1:0]);
        case (op)
            soc_pkg::MEM_BYTE, soc_pkg::MEM_BYTE_U: mask = 32'h0000_00FF << shift;
            soc_pkg::MEM_HALF, soc_pkg::MEM_HALF_U: mask = 32'h0000_FFFF << shift;
            default:                                mask = 32'hFFFF_FFFF;
        endcase
        shadow[addr[soc_pkg::DMEM_AW+1:2]] =
            (shadow_word(addr) & ~mask) | ((data << shift) & mask);
    endfunction

    // rv32 load rule: pick the lane, then sign or zero extend
    function automatic logic [31:0] expected_load(
        input logic [31:0]      word,
        input logic [31:0]      addr,
        input soc_pkg::mem_op_e op
    );
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * int'(addr[1:0])));
        h = 16'(word >> (8 * int'(addr[1:0])));
        case (op)
            soc_pkg::MEM_BYTE:   return {{24{b[7]}}, b};
            soc_pkg::MEM_BYTE_U: return {24'h0, b};
            soc_pkg::MEM_HALF:   return {{16{h[15]}}, h};
            soc_pkg::MEM_HALF_U: return {16'h0, h};
            default:             return word;
        endcase
    endfunction

    // ========================================
    // four-phase transfer
    // ========================================
    task automatic transfer(
        input  logic [31:0]      addr,
        input  logic [31:0]      wdata,
        input  logic             write,
        input  soc_pkg::mem_op_e op,
        input  int               ack_cycle,
        output logic [31:0]      rdata,
        output logic             err
    );
        int n;
        @(posedge clk);
        req_data <= '{addr: addr, wdata: wdata, write: write, op: op};
        req_i    <= 1'b1;
        // cycle 0 is the one that ends with req sampled high
        n = 0;
        @(negedge clk);
        while (!ack)
        begin
            n++;
            if (n > WAIT_LIMIT) give_up("ack_o to rise");
            @(negedge clk);
        end
        check_value("ack cycle", ack_cycle, n);
        rdata = rsp.rdata;
        err   = rsp.err;
        @(posedge clk);
        req_i <= 1'b0;
        // ack falls one cycle after req is seen low
        n = 0;
        @(negedge clk);
        while (ack)
        begin
            n++;
            if (n > WAIT_LIMIT) give_up("ack_o to fall");
            @(negedge clk);
        end
        check_value("ack release", 1, n);
    endtask

    task automatic store(input logic [31:0] addr, input logic [31:0] data,
                         input soc_pkg::mem_op_e op);
        logic [31:0] ignored;
        logic        err;
        transfer(addr, data, 1'b1, op, 3, ignored, err);
        check_value("store err", 32'h0, {31'h0, err});
    endtask

    task automatic load(input logic [31:0] addr, input soc_pkg::mem_op_e op,
                        output logic [31:0] data);
        logic err;
        transfer(addr, 32'h0, 1'b0, op, 3, data, err);
        check_value("load err", 32'h0, {31'h0, err});
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (timer_irq !== level)
        begin
            n++;
            if (n > WAIT_LIMIT) give_up("timer_irq_o to change");
            @(negedge clk);
        end
    endtask

    // ========================================
    // test sequence
    // ========================================
    initial
    begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] t0;
        logic [31:0] t1;
        logic        err;
        reset_i   = 1'b1;
        req_i     = 1'b0;
        req_data  = '0;
        gpio_in   = 32'h0;
        lfsr_q    = 16'd26;
        word_list = '{0, 1, 5, 17, 200, 259};
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;

        // word memory, 259 lands on word 3
        for (int i = 0; i < 6; i++)
        begin
            addr = soc_pkg::DMEM_BASE + 32'(word_list[i]) * 32'd4;
            data = rand_bits(32);
            store(addr, data, soc_pkg::MEM_WORD);
            shadow_store(addr, data, soc_pkg::MEM_WORD);
        end
        for (int i = 0; i < 6; i++)
        begin
            addr = soc_pkg::DMEM_BASE + 32'(word_list[i]) * 32'd4;
            load(addr, soc_pkg::MEM_WORD, data);
            check_value("word readback", shadow_word(addr), data);
        end
        load(soc_pkg::DMEM_BASE + 32'hC, soc_pkg::MEM_WORD, data);
        check_value("wrapped word", shadow_word(32'hC), data);

        // narrow stores into word 1, negative values forced
        store(32'h6, rand_bits(8) | 32'h80, soc_pkg::MEM_BYTE);
        shadow_store(32'h6, req_data.wdata, soc_pkg::MEM_BYTE);
        store(32'h4, rand_bits(16) | 32'h8000, soc_pkg::MEM_HALF);
        shadow_store(32'h4, req_data.wdata, soc_pkg::MEM_HALF);
        load(32'h4, soc_pkg::MEM_WORD, data);
        check_value("lane merge", shadow_word(32'h4), data);
        for (int lane = 0; lane < 4; lane++)
        begin
            addr = 32'h4 + 32'(lane);
            load(addr, soc_pkg::MEM_BYTE, data);
            check_value("byte signed", expected_load(shadow_word(addr), addr,
                        soc_pkg::MEM_BYTE), data);
            load(addr, soc_pkg::MEM_BYTE_U, data);
            check_value("byte unsigned", expected_load(shadow_word(addr), addr,
                        soc_pkg::MEM_BYTE_U), data);
        end
        for (int lane = 0; lane < 4; lane += 2)
        begin
            addr = 32'h4 + 32'(lane);
            load(addr, soc_pkg::MEM_HALF, data);
            check_value("half signed", expected_load(shadow_word(addr), addr,
                        soc_pkg::MEM_HALF), data);
            load(addr, soc_pkg::MEM_HALF_U, data);
            check_value("half unsigned", expected_load(shadow_word(addr), addr,
                        soc_pkg::MEM_HALF_U), data);
        end

        // gpio out, enable and synchronized input
        data = rand_bits(32);
        store(soc_pkg::GPIO_BASE | 32'(soc_pkg::GPIO_OUT), data, soc_pkg::MEM_WORD);
        check_value("gpio out pins", data, gpio_out);
        load(soc_pkg::GPIO_BASE | 32'(soc_pkg::GPIO_OUT), soc_pkg::MEM_WORD, t0);
        check_value("gpio out read", data, t0);
        data = rand_bits(32);
        store(soc_pkg::GPIO_BASE | 32'(soc_pkg::GPIO_OE), data, soc_pkg::MEM_WORD);
        check_value("gpio oe pins", data, gpio_oe);
        data = rand_bits(32);
        @(posedge clk);
        gpio_in <= data;
        repeat (3) @(posedge clk);
        load(soc_pkg::GPIO_BASE | 32'(soc_pkg::GPIO_IN), soc_pkg::MEM_WORD, t0);
        check_value("gpio in read", data, t0);

        // timer count, compare and irq
        load(soc_pkg::CLINT_BASE | 32'(soc_pkg::MTIME_LO), soc_pkg::MEM_WORD, t0);
        load(soc_pkg::CLINT_BASE | 32'(soc_pkg::MTIME_LO), soc_pkg::MEM_WORD, t1);
        check_value("mtime increasing", 32'h1, {31'h0, t1 > t0});
        store(soc_pkg::CLINT_BASE | 32'(soc_pkg::MTIMECMP_HI), 32'h0, soc_pkg::MEM_WORD);
        store(soc_pkg::CLINT_BASE | 32'(soc_pkg::MTIMECMP_LO), t1 + 32'd40, soc_pkg::MEM_WORD);
        check_value("irq before compare", 32'h0, {31'h0, timer_irq});
        wait_irq(1'b1);
        store(soc_pkg::CLINT_BASE | 32'(soc_pkg::MTIMECMP_HI), 32'hFFFF_FFFF, soc_pkg::MEM_WORD);
        store(soc_pkg::CLINT_BASE | 32'(soc_pkg::MTIMECMP_LO), 32'hFFFF_FFFF, soc_pkg::MEM_WORD);
        wait_irq(1'b0);

        // unmapped and misaligned both refused
        transfer(32'h1000_0000, rand_bits(32), 1'b1, soc_pkg::MEM_WORD, 3, data, err);
        check_value("unmapped err", 32'h1, {31'h0, err});
        transfer(32'h0000_0006, rand_bits(32), 1'b1, soc_pkg::MEM_WORD, 1, data, err);
        check_value("misaligned err", 32'h1, {31'h0, err});
        load(32'h4, soc_pkg::MEM_WORD, data);
        check_value("word after refusal", shadow_word(32'h4), data);

        if (DUT.props.fail_count == 0)
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
        else
        begin
            $display("bus protocol assertions failed");
            stop_run();
        end
    end

endmodule
